//--- median_defines.svh
/*
  Compile-time sizes for the 3x3 median filter.
  Included by the package and by every module that needs a size or a count.
*/
`ifndef MEDIAN_DEFINES_SVH
`define MEDIAN_DEFINES_SVH

// bits per grey pixel
`define PIX_W       8

// pixels per image line, sets the line buffer length
`define IMG_W       8

// result buffer entries and credits granted by the sink after reset
`define FIFO_DEPTH  8
`define OUT_CREDITS 4

`endif

//--- median_pkg.sv
/*
  Pixel, input beat and 3x3 window types for the median filter.
  Modules pull these in with a wildcard import in their header.
*/
`default_nettype none

`include "median_defines.svh"

package median_pkg;

    // one grey pixel
    typedef logic [`PIX_W-1:0] pix_t;

    // input beat, sof marks the first pixel of a frame
    typedef struct packed {
        pix_t pix;
        logic sof;
    } pix_beat_t;

    // one window row, c0 is the oldest pixel
    typedef struct packed {
        pix_t c2;
        pix_t c1;
        pix_t c0;
    } win_row_t;

    // 3x3 neighbourhood, r0 is the oldest line
    typedef struct packed {
        win_row_t r2;
        win_row_t r1;
        win_row_t r0;
    } window_t;

endpackage

`default_nettype wire

//--- sort3.sv
/*
  Registered three-input sorter.
  Orders a, b and c into lo, md and hi one cycle after the inputs.
*/
`timescale 1ns/1ps
`default_nettype none

module sort3
    import median_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire pix_t a,
    input  wire pix_t b,
    input  wire pix_t c,
    output pix_t      lo,
    output pix_t      md,
    output pix_t      hi
);

    pix_t ab_lo;
    pix_t ab_hi;
    pix_t mid_lo;
    pix_t mid_hi;

    // first compare-swap on a and b
    assign ab_lo = (a > b) ? b : a;
    assign ab_hi = (a > b) ? a : b;

    // larger of the pair against c gives the maximum
    assign mid_hi = (ab_hi > c) ? ab_hi : c;
    assign mid_lo = (ab_hi > c) ? c : ab_hi;

    // last swap splits the minimum from the median
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lo <= '0;
            md <= '0;
            hi <= '0;
        end else begin
            lo <= (ab_lo > mid_lo) ? mid_lo : ab_lo;
            md <= (ab_lo > mid_lo) ? ab_lo : mid_lo;
            hi <= mid_hi;
        end
    end

endmodule

`default_nettype wire

//--- median9.sv
/*
  Pipelined median-of-nine core, one window in per cycle.
  Row sort, then column pick, then a final sort; med_valid follows
  win_valid by three cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module median9
    import median_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire logic    win_valid,
    input  wire window_t win,
    output logic         med_valid,
    output pix_t         med
);

    // window viewed as [row][col]
    pix_t [2:0][2:0] win_px;

    // stage 1 results, one set per row
    pix_t [2:0] row_lo;
    pix_t [2:0] row_md;
    pix_t [2:0] row_hi;

    // stage 2 registers
    pix_t max_of_lo;
    pix_t mid_of_md;
    pix_t min_of_hi;

    // valid chain alongside the data stages
    logic [2:0] vld_q;

    function automatic pix_t pmin(input pix_t x, input pix_t y);
        return (x > y) ? y : x;
    endfunction

    function automatic pix_t pmax(input pix_t x, input pix_t y);
        return (x > y) ? x : y;
    endfunction

    // median of three built from min and max
    function automatic pix_t pmid(input pix_t x, input pix_t y, input pix_t z);
        return pmax(pmin(x, y), pmin(pmax(x, y), z));
    endfunction

    assign win_px = win;

    // stage 1 sorts each row
    for (genvar r = 0; r < 3; r++) begin : g_row
        sort3 u_row_sort (
            .clk   (clk),
            .rst_n (rst_n),
            .a     (win_px[r][0]),
            .b     (win_px[r][1]),
            .c     (win_px[r][2]),
            .lo    (row_lo[r]),
            .md    (row_md[r]),
            .hi    (row_hi[r])
        );
    end

    // stage 2 keeps the three candidates that bracket the median
    always_ff @(posedge clk) begin
        max_of_lo <= pmax(pmax(row_lo[0], row_lo[1]), row_lo[2]);
        mid_of_md <= pmid(row_md[0], row_md[1], row_md[2]);
        min_of_hi <= pmin(pmin(row_hi[0], row_hi[1]), row_hi[2]);
    end

    // stage 3 takes the middle candidate
    sort3 u_final_sort (
        .clk   (clk),
        .rst_n (rst_n),
        .a     (max_of_lo),
        .b     (mid_of_md),
        .c     (min_of_hi),
        .lo    (),
        .md    (med),
        .hi    ()
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[1:0], win_valid};
        end
    end

    assign med_valid = vld_q[2];

endmodule

`default_nettype wire

//--- window_gen.sv
/*
  3x3 window generator for raster input.
  Two line buffers feed a shifting window; a window is issued one cycle
  after each accepted pixel at row 2 or later and column 2 or later.
*/
`timescale 1ns/1ps
`default_nettype none

`include "median_defines.svh"

module window_gen
    import median_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      in_valid,
    input  wire pix_beat_t in_beat,
    input  wire logic      in_ready,
    output logic           win_valid,
    output window_t        win
);

    localparam int COL_W = $clog2(`IMG_W);
    localparam logic [COL_W-1:0] LAST_COL = COL_W'(`IMG_W - 1);

    // lb1 holds the previous line, lb2 the line before it
    pix_t lb1 [`IMG_W];
    pix_t lb2 [`IMG_W];

    logic [COL_W-1:0] col_cnt;
    // row index, capped at 2 since only row >= 2 matters
    logic [1:0]       row_cnt;

    logic [COL_W-1:0] cur_col;
    logic [1:0]       cur_row;
    logic             xfer;
    logic             interior;
    pix_t             up1;
    pix_t             up2;
    window_t          win_q;

    assign xfer = in_valid && in_ready;

    // sof puts this pixel at the top left corner
    assign cur_col = in_beat.sof ? '0 : col_cnt;
    assign cur_row = in_beat.sof ? '0 : row_cnt;

    assign interior = (cur_row == 2'd2) && (cur_col >= COL_W'(2));

    // pixels directly above the current one
    assign up1 = lb1[cur_col];
    assign up2 = lb2[cur_col];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (xfer) begin
            if (cur_col == LAST_COL) begin
                col_cnt <= '0;
            end else begin
                col_cnt <= cur_col + 1'b1;
            end
            // advance row at end of line, hold once at 2
            if (cur_col == LAST_COL && cur_row != 2'd2) begin
                row_cnt <= cur_row + 2'd1;
            end else begin
                row_cnt <= cur_row;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= xfer && interior;
        end
    end

    // line buffers shift down one line per column slot
    always_ff @(posedge clk) begin
        if (xfer) begin
            lb2[cur_col] <= up1;
            lb1[cur_col] <= in_beat.pix;
        end
    end

    // window shifts left, new column enters at c2
    always_ff @(posedge clk) begin
        if (xfer) begin
            win_q.r0 <= '{c2: up2, c1: win_q.r0.c2, c0: win_q.r0.c1};
            win_q.r1 <= '{c2: up1, c1: win_q.r1.c2, c0: win_q.r1.c1};
            win_q.r2 <= '{c2: in_beat.pix, c1: win_q.r2.c2, c0: win_q.r2.c1};
        end
    end

    assign win = win_q;

endmodule

`default_nettype wire

//--- result_fifo.sv
/*
  Output buffer for median results with credit-based send.
  A slot is reserved per issued window so results never overflow;
  each beat sent costs one credit, out_credit returns one.
*/
`timescale 1ns/1ps
`default_nettype none

`include "median_defines.svh"

module result_fifo
    import median_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic win_valid,
    input  wire logic med_valid,
    input  wire pix_t med,
    input  wire logic out_credit,
    output logic      in_ready,
    output logic      out_valid,
    output pix_t      out_pix
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);
    localparam int SUM_W = CNT_W + 1;
    localparam int CRD_W = $clog2(`OUT_CREDITS + 1);

    pix_t mem [`FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // entries holding a result
    logic [CNT_W-1:0] fill_cnt;
    // slots promised to windows, buffered or still in the core
    logic [CNT_W-1:0] resv_cnt;
    logic [CRD_W-1:0] credit_cnt;
    logic [SUM_W-1:0] resv_ahead;
    logic             send;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign send = (credit_cnt != '0) && (fill_cnt != '0);

    // count the window issued this cycle, its pixel was accepted last cycle
    assign resv_ahead = SUM_W'(resv_cnt) + SUM_W'(win_valid);
    assign in_ready   = resv_ahead < SUM_W'(`FIFO_DEPTH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_cnt   <= '0;
            resv_cnt   <= '0;
            credit_cnt <= CRD_W'(`OUT_CREDITS);
            out_valid  <= 1'b0;
        end else begin
            if (med_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (send) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            fill_cnt   <= fill_cnt + CNT_W'(med_valid) - CNT_W'(send);
            resv_cnt   <= resv_cnt + CNT_W'(win_valid) - CNT_W'(send);
            // return and spend may land in the same cycle
            credit_cnt <= credit_cnt + CRD_W'(out_credit) - CRD_W'(send);
            out_valid  <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (med_valid) begin
            mem[wr_ptr] <= med;
        end
        if (send) begin
            out_pix <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

//--- median_filter.sv
/*
  Streaming 3x3 median filter top level.
  Pixels in under ready/valid with sof, medians of interior windows out
  under credit flow control.
*/
`timescale 1ns/1ps
`default_nettype none

module median_filter
    import median_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      in_valid,
    input  wire pix_beat_t in_beat,
    output logic           in_ready,
    output logic           out_valid,
    output pix_t           out_pix,
    input  wire logic      out_credit
);

    // window path from producer to core
    logic    win_valid;
    window_t win;

    // median path from core to buffer
    logic    med_valid;
    pix_t    med;

    window_gen u_window_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_ready  (in_ready),
        .win_valid (win_valid),
        .win       (win)
    );

    median9 u_median9 (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_valid (win_valid),
        .win       (win),
        .med_valid (med_valid),
        .med       (med)
    );

    // win_valid also goes here to reserve a slot per window
    result_fifo u_result_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .win_valid  (win_valid),
        .med_valid  (med_valid),
        .med        (med),
        .out_credit (out_credit),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_pix    (out_pix)
    );

endmodule

`default_nettype wire

//--- tb_median_filter.sv
/*
  Testbench for the streaming 3x3 median filter.
  Streams a table of frames back to back, predicts every median and checks
  output order, the credit bound and input stalls.
*/
`timescale 1ns/1ps
`default_nettype none

`include "median_defines.svh"

module tb_median_filter
    import median_pkg::*;
();

    localparam int NUM_CASES = 8;
    localparam int MAX_ROWS  = 8;

    // pixel modes of a table entry
    localparam logic [1:0] M_RAND    = 2'd0;
    localparam logic [1:0] M_CONST   = 2'd1;
    localparam logic [1:0] M_IMPULSE = 2'd2;
    localparam logic [1:0] M_RAMP    = 2'd3;

    // one frame of the stimulus table
    typedef struct packed {
        logic [3:0] rows;
        logic [1:0] mode;
        pix_t       val;
        logic       gaps;
        logic [5:0] dly;
        logic       rnd_dly;
        logic       stall;
    } case_t;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    pix_beat_t in_beat;
    logic      in_ready;
    logic      out_valid;
    pix_t      out_pix;
    logic      out_credit;

    case_t       cases [NUM_CASES];
    pix_t        frame [MAX_ROWS][`IMG_W];
    pix_t        exp_q [$];
    // cycle at which each pending credit goes back
    int          due_q [$];
    logic [31:0] pix_st;
    logic [31:0] crd_st;
    int          cycle;
    int          limit;
    int          sent;
    int          returned;
    int          stall_cnt;
    int          cur_dly;
    logic        cur_rnd;

    median_filter DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_beat    (in_beat),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_pix    (out_pix),
        .out_credit (out_credit)
    );

    always #2 clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] lfsr_take(inout logic [31:0] st, input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            r  = {r[30:0], st[0]};
            st = st[0] ? ((st >> 1) ^ 32'hD000_0001) : (st >> 1);
        end
        return r;
    endfunction

    // reference median by a full sort of the nine values
    function automatic pix_t median_of(input pix_t v [9]);
        pix_t s [9];
        pix_t t;
        s = v;
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8 - i; j++) begin
                if (s[j] > s[j+1]) begin
                    t      = s[j];
                    s[j]   = s[j+1];
                    s[j+1] = t;
                end
            end
        end
        return s[4];
    endfunction

    function automatic case_t make_case(input int rows, input logic [1:0] mode,
                                        input pix_t val, input logic gaps, input int dly,
                                        input logic rnd, input logic stall);
        case_t c;
        c.rows    = 4'(rows);
        c.mode    = mode;
        c.val     = val;
        c.gaps    = gaps;
        c.dly     = 6'(dly);
        c.rnd_dly = rnd;
        c.stall   = stall;
        return c;
    endfunction

    task automatic fail_run(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // holds the beat until the buffer grants it
    task automatic send_pixel(input pix_t p, input logic s);
        @(negedge clk);
        in_valid = 1'b1;
        in_beat  = '{pix: p, sof: s};
        while (!in_ready) begin
            stall_cnt++;
            @(negedge clk);
        end
    endtask

    task automatic run_case(input case_t tc);
        pix_t win9 [9];
        pix_t expv;
        int   rows;
        // new credit settings take effect away from the monitor's falling edge
        @(posedge clk);
        rows      = int'(tc.rows);
        cur_dly   = int'(tc.dly);
        cur_rnd   = tc.rnd_dly;
        stall_cnt = 0;
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < `IMG_W; c++) begin
                case (tc.mode)
                    M_RAND:    frame[r][c] = pix_t'(lfsr_take(pix_st, 8));
                    M_CONST:   frame[r][c] = tc.val;
                    M_IMPULSE: frame[r][c] = (r == 2 && c == 3) ? 8'hff : tc.val;
                    default:   frame[r][c] = pix_t'(int'(tc.val) + c * 16);
                endcase
            end
        end
        // interior windows only in raster order
        for (int r = 2; r < rows; r++) begin
            for (int c = 2; c < `IMG_W; c++) begin
                if (tc.mode == M_RAND) begin
                    for (int i = 0; i < 9; i++) begin
                        win9[i] = frame[r - 2 + i / 3][c - 2 + i % 3];
                    end
                    expv = median_of(win9);
                end else if (tc.mode == M_RAMP) begin
                    // middle column of the window
                    expv = pix_t'(int'(tc.val) + (c - 1) * 16);
                end else begin
                    expv = tc.val;
                end
                exp_q.push_back(expv);
            end
        end
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < `IMG_W; c++) begin
                if (tc.gaps && lfsr_take(pix_st, 2) == 32'd0) begin
                    @(negedge clk);
                    in_valid = 1'b0;
                end
                send_pixel(frame[r][c], r == 0 && c == 0);
            end
        end
        if (tc.stall) begin
            check_eq("in_ready_fell", 32'(stall_cnt != 0), 32'd1);
        end
    endtask

    // output monitor with credit sink and watchdog
    always @(negedge clk) begin
        if (rst_n) begin
            cycle++;
            if (cycle > limit) begin
                fail_run("timeout, outputs stopped before all medians arrived");
            end
            if (out_credit) begin
                returned++;
            end
            out_credit = 1'b0;
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    fail_run("output beat with no median expected");
                end
                check_eq("out_pix", 32'(out_pix), 32'(exp_q.pop_front()));
                sent++;
                due_q.push_back(cycle + (cur_rnd ? int'(lfsr_take(crd_st, 4)) : cur_dly));
            end
            if (sent - returned > `OUT_CREDITS) begin
                fail_run("more beats outstanding than credits granted");
            end
            if (due_q.size() != 0 && due_q[0] <= cycle) begin
                void'(due_q.pop_front());
                out_credit = 1'b1;
            end
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_beat    = '0;
        out_credit = 1'b0;
        pix_st     = 32'd68199;
        crd_st     = 32'd68199;
        cycle      = 0;
        sent       = 0;
        returned   = 0;
        cur_dly    = 0;
        cur_rnd    = 1'b0;
        cases[0] = make_case(6, M_RAND, 8'h00, 1'b0, 0, 1'b0, 1'b0);
        cases[1] = make_case(4, M_CONST, 8'h5a, 1'b0, 1, 1'b0, 1'b0);
        cases[2] = make_case(5, M_IMPULSE, 8'h20, 1'b0, 0, 1'b0, 1'b0);
        cases[3] = make_case(4, M_RAMP, 8'h03, 1'b0, 0, 1'b0, 1'b0);
        // two rows only so no windows before the next sof
        cases[4] = make_case(2, M_RAND, 8'h00, 1'b0, 0, 1'b0, 1'b0);
        cases[5] = make_case(5, M_RAND, 8'h00, 1'b0, 24, 1'b0, 1'b1);
        cases[6] = make_case(7, M_RAND, 8'h00, 1'b1, 0, 1'b1, 1'b0);
        cases[7] = make_case(3, M_CONST, 8'hff, 1'b1, 2, 1'b0, 1'b0);
        // budget grows with pixels and credit delay
        limit = 200;
        for (int k = 0; k < NUM_CASES; k++) begin
            limit += int'(cases[k].rows) * `IMG_W
                     * ((cases[k].rnd_dly ? 16 : int'(cases[k].dly)) + 8);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // idle after reset
        repeat (4) begin
            @(negedge clk);
            check_eq("out_valid", 32'(out_valid), 32'd0);
            check_eq("in_ready", 32'(in_ready), 32'd1);
        end
        for (int k = 0; k < NUM_CASES; k++) begin
            run_case(cases[k]);
        end
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // any late extra beat trips the monitor
        repeat (16) @(negedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
median_pkg.sv
sort3.sv
median9.sv
window_gen.sv
result_fifo.sv
median_filter.sv
tb_median_filter.sv

//--- run.sh
#!/bin/sh
# Builds the median filter testbench with Verilator and runs it.
# Exits non-zero when the build fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f flist.f --top-module tb_median_filter \
    -o sim_median_filter
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_median_filter > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "simulation passed"
exit 0
